/* hdl/iq_cfg_pkg.sv */
`default_nettype none

package iq_cfg_pkg;

	// Total number of slots over both columns.
	localparam int IQ_SIZE = 16;

	// Each column holds half of the queue and compacts on its own.
	localparam int IQ_LENGTH = IQ_SIZE / 2;

	localparam int IQ_WB_PORTS = 4; // Writeback tags broadcast per cycle.

	// Field widths of a micro-op.
	localparam int REG_W = 5;
	localparam int ROB_W = 5;
	localparam int BRM_W = 3; // One bit per unresolved branch.
	localparam int OP_W  = 7;

endpackage

`default_nettype wire

/* hdl/iq_types_pkg.sv */
`default_nettype none

package iq_types_pkg;

	import iq_cfg_pkg::*;

	typedef logic [REG_W-1:0] iq_reg_t;
	typedef logic [BRM_W-1:0] iq_brm_t;

	// Micro-op as it leaves the queue, 30 bits.
	typedef struct packed {
		logic [OP_W-1:0]  opcode;
		iq_brm_t          brmask;
		logic [ROB_W-1:0] rob;
		iq_reg_t          dst;
		iq_reg_t          src1;
		iq_reg_t          src2;
	} iq_uop_t;

	// Queue entry with its state flags, 33 bits.
	typedef struct packed {
		iq_uop_t uop;
		logic    valid;
		logic    rdy1;
		logic    rdy2;
	} iq_entry_t;

	typedef struct packed {
		logic    valid;
		iq_reg_t tag;
	} iq_wb_port_t;

	typedef struct packed {
		iq_wb_port_t [IQ_WB_PORTS-1:0] port;
	} iq_wb_t;

	// True when any valid writeback port carries the given tag.
	function automatic logic iq_tag_hit(input iq_reg_t tag, input iq_wb_t wb);
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < IQ_WB_PORTS; p++) begin
			hit = hit | (wb.port[p].valid & (wb.port[p].tag == tag));
		end
		return hit;
	endfunction

	function automatic iq_entry_t iq_wakeup(input iq_entry_t e, input iq_wb_t wb);
		iq_entry_t w;
		w = e;
		w.rdy1 = e.rdy1 | iq_tag_hit(e.uop.src1, wb);
		w.rdy2 = e.rdy2 | iq_tag_hit(e.uop.src2, wb);
		return w;
	endfunction

	// A uop dies when it depends on any branch being squashed.
	function automatic logic iq_hit_kill(input iq_uop_t u, input iq_brm_t kill);
		return |(u.brmask & kill);
	endfunction

endpackage

`default_nettype wire

/* hdl/iq_slot.sv */
`timescale 1ns/100ps
`default_nettype none

module iq_slot import iq_types_pkg::*; (
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  logic      i_en,
	input  iq_entry_t i_entry,
	input  logic      i_take,
	input  logic      i_grant,
	input  iq_wb_t    i_wb,
	input  iq_brm_t   i_brkill,
	output iq_entry_t o_entry,
	output logic      o_take,
	output logic      o_request,
	output iq_uop_t   o_uop
);

	logic      r_valid;
	iq_uop_t   r_uop;
	logic      r_rdy1;
	logic      r_rdy2;

	iq_entry_t held;
	iq_entry_t held_w;
	iq_entry_t in_w;
	logic      killed;
	logic      in_live;
	logic      free;
	logic      load;
	logic      nxt_valid;

	always_comb begin
		held.uop   = r_uop;
		held.valid = r_valid;
		held.rdy1  = r_rdy1;
		held.rdy2  = r_rdy2;
	end

	assign killed = r_valid & iq_hit_kill(r_uop, i_brkill);

	// A killed entry must not issue in the same cycle as the kill.
	assign o_request = r_valid & r_rdy1 & r_rdy2 & ~killed;

	// The slot can accept a new entry if it leaves this cycle anyway.
	assign free = ~r_valid | i_grant | killed;

	// The entry above may itself be hit by this cycle's kill.
	assign in_live = i_entry.valid & ~iq_hit_kill(i_entry.uop, i_brkill);

	assign load   = i_en & free & in_live;
	assign o_take = load;

	// Wakeup applies to the kept entry and to the one moving in.
	assign held_w = iq_wakeup(held, i_wb);
	assign in_w   = iq_wakeup(i_entry, i_wb);

	always_comb begin
		if (i_take) begin
			nxt_valid = 1'b0; // Moved two rows down.
		end else if (load) begin
			nxt_valid = 1'b1;
		end else if (free) begin
			nxt_valid = 1'b0;
		end else begin
			nxt_valid = r_valid;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= nxt_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			r_uop  <= in_w.uop;
			r_rdy1 <= in_w.rdy1;
			r_rdy2 <= in_w.rdy2;
		end else begin
			r_rdy1 <= held_w.rdy1;
			r_rdy2 <= held_w.rdy2;
		end
	end

	// The lower slot or the top level decides what this entry means for it.
	assign o_entry = held;

	// Zero unless granted so that the column can OR all slots together.
	assign o_uop = i_grant ? r_uop : '0;

endmodule

`default_nettype wire

/* hdl/iq_select.sv */
`timescale 1ns/100ps
`default_nettype none

module iq_select import iq_cfg_pkg::*; (
	input  logic [IQ_LENGTH-1:0] i_request,
	output logic [IQ_LENGTH-1:0] o_grant,
	output logic                 o_valid
);

	// Index zero holds the oldest entry of the column.
	always_comb begin
		logic found;
		found   = 1'b0;
		o_grant = '0;
		for (int i = 0; i < IQ_LENGTH; i++) begin
			if (i_request[i] && !found) begin
				o_grant[i] = 1'b1;
				found      = 1'b1;
			end
		end
	end

	assign o_valid = |i_request;

endmodule

`default_nettype wire

/* hdl/issue_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_queue import iq_cfg_pkg::*, iq_types_pkg::*; (
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  logic      i_en,
	input  iq_entry_t i_entry1,
	input  iq_entry_t i_entry2,
	input  iq_entry_t i_entry3,
	input  iq_entry_t i_entry4,
	input  iq_wb_t    i_wb,
	input  iq_brm_t   i_brkill,
	output logic      o_full,
	output iq_uop_t   o_issue1,
	output iq_uop_t   o_issue2,
	output logic      o_valid1,
	output logic      o_valid2
);

	genvar i, j;

	iq_entry_t                ent   [2][IQ_LENGTH];
	iq_uop_t                  uop   [2][IQ_LENGTH];
	iq_entry_t                ins   [2][2];
	logic     [IQ_LENGTH-1:0] req   [2];
	logic     [IQ_LENGTH-1:0] gnt   [2];
	logic     [IQ_LENGTH-1:0] take  [2];
	iq_uop_t                  issue [2];
	logic                     valid [2];
	logic                     ins_en;

	// Odd entries go to column 0, even entries to column 1.
	assign ins[0][0] = i_entry1;
	assign ins[0][1] = i_entry3;
	assign ins[1][0] = i_entry2;
	assign ins[1][1] = i_entry4;

	// Full looks only at the held state of the two top rows.
	assign o_full = ent[0][IQ_LENGTH-2].valid | ent[0][IQ_LENGTH-1].valid |
	                ent[1][IQ_LENGTH-2].valid | ent[1][IQ_LENGTH-1].valid;

	assign ins_en = i_en & ~o_full;

	generate
		for (j = 0; j < 2; j++) begin : g_col
			for (i = 0; i < IQ_LENGTH; i++) begin : g_slot
				iq_entry_t feed;
				logic      en_in;
				logic      take_in;

				if (i >= IQ_LENGTH - 2) begin : g_top
					assign feed  = ins[j][i-(IQ_LENGTH-2)];
					assign en_in = ins_en;
				end else begin : g_chain
					// An entry granted this cycle stays out of the chain.
					always_comb begin
						feed       = ent[j][i+2];
						feed.valid = ent[j][i+2].valid & ~gnt[j][i+2];
					end
					assign en_in = 1'b1;
				end

				if (i >= 2) begin : g_below
					assign take_in = take[j][i-2];
				end else begin : g_bottom
					assign take_in = 1'b0; // Nothing below the oldest rows.
				end

				iq_slot slot_i (
					.i_clk     (i_clk),
					.i_arst_n  (i_arst_n),
					.i_en      (en_in),
					.i_entry   (feed),
					.i_take    (take_in),
					.i_grant   (gnt[j][i]),
					.i_wb      (i_wb),
					.i_brkill  (i_brkill),
					.o_entry   (ent[j][i]),
					.o_take    (take[j][i]),
					.o_request (req[j][i]),
					.o_uop     (uop[j][i])
				);
			end

			iq_select select_i (
				.i_request (req[j]),
				.o_grant   (gnt[j]),
				.o_valid   (valid[j])
			);

			// At most one slot drives a non-zero uop per column.
			always_comb begin
				issue[j] = '0;
				for (int k = 0; k < IQ_LENGTH; k++) begin
					issue[j] = issue[j] | uop[j][k];
				end
			end
		end
	endgenerate

	assign o_issue1 = issue[0];
	assign o_issue2 = issue[1];
	assign o_valid1 = valid[0];
	assign o_valid2 = valid[1];

endmodule

`default_nettype wire

/* dv/iq_ref_model.svh */
`ifndef IQ_REF_MODEL_SVH
`define IQ_REF_MODEL_SVH

// Image of both columns. Row 0 holds the oldest entry of a column.
iq_entry_t col_img [2][IQ_LENGTH];

function automatic logic tag_seen(input iq_reg_t tag, input iq_wb_t wb);
	for (int p = 0; p < IQ_WB_PORTS; p++) begin
		if (wb.port[p].valid && wb.port[p].tag == tag) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

function automatic iq_entry_t woken(input iq_entry_t e, input iq_wb_t wb);
	iq_entry_t w;
	w      = e;
	w.rdy1 = e.rdy1 || tag_seen(e.uop.src1, wb);
	w.rdy2 = e.rdy2 || tag_seen(e.uop.src2, wb);
	return w;
endfunction

// Counts held entries, only the two top rows of each column when top_only is set.
function automatic int held_count(input logic top_only);
	int n;
	n = 0;
	for (int c = 0; c < 2; c++) begin
		for (int r = top_only ? IQ_LENGTH - 2 : 0; r < IQ_LENGTH; r++) begin
			n += int'(col_img[c][r].valid);
		end
	end
	return n;
endfunction

// Advances one column by one clock and returns whether it issues.
function automatic logic step_column(input int c, input iq_entry_t older,
		input iq_entry_t younger, input logic do_ins, input iq_wb_t wb,
		input iq_brm_t kill, output iq_uop_t uop, output int killed);
	iq_entry_t cur   [IQ_LENGTH];
	iq_entry_t above [IQ_LENGTH];
	logic      gone  [IQ_LENGTH];
	logic      pull  [IQ_LENGTH];
	int        pick;
	pick   = -1;
	killed = 0;
	for (int r = 0; r < IQ_LENGTH; r++) begin
		cur[r]  = col_img[c][r];
		gone[r] = !cur[r].valid;
		if (cur[r].valid && (cur[r].uop.brmask & kill) != '0) begin
			gone[r] = 1'b1; // Squashed before it can request.
			killed++;
		end else if (cur[r].valid && cur[r].rdy1 && cur[r].rdy2 && pick < 0) begin
			pick    = r;
			gone[r] = 1'b1;
		end
	end
	// Each row pulls from two rows up, and the top rows from the insert ports.
	for (int r = 0; r < IQ_LENGTH; r++) begin
		if (r < IQ_LENGTH - 2) begin
			above[r]       = cur[r+2];
			above[r].valid = cur[r+2].valid && (r + 2 != pick);
		end else begin
			above[r]       = (r == IQ_LENGTH - 2) ? older : younger;
			above[r].valid = above[r].valid && do_ins;
		end
		pull[r] = gone[r] && above[r].valid && (above[r].uop.brmask & kill) == '0;
	end
	for (int r = 0; r < IQ_LENGTH; r++) begin
		if (r >= 2 && pull[r-2]) begin
			col_img[c][r] = '0;
		end else if (pull[r]) begin
			col_img[c][r] = woken(above[r], wb);
		end else if (gone[r]) begin
			col_img[c][r] = '0;
		end else begin
			col_img[c][r] = woken(cur[r], wb);
		end
	end
	uop = '0;
	if (pick >= 0) begin
		uop = cur[pick].uop;
	end
	return pick >= 0;
endfunction

`endif

/* dv/tb_issue_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_issue_queue import iq_cfg_pkg::*, iq_types_pkg::*;;

	localparam int CLK_NS       = 8;
	localparam int RESET_CYCLES = 16;
	localparam int STIM_CYCLES  = 3000;
	localparam int DRAIN_CYCLES = 500;
	localparam int LIMIT_NS     = (2 * STIM_CYCLES + DRAIN_CYCLES) * CLK_NS;

	logic      clk;
	logic      arst_n;
	logic      en;
	iq_entry_t entry [4];
	iq_wb_t    wb;
	iq_brm_t   brkill;
	logic      full;
	iq_uop_t   issue1;
	iq_uop_t   issue2;
	logic      valid1;
	logic      valid2;

	int mismatches = 0;
	int failures   = 0;
	int issued     = 0;
	int dual       = 0;
	int kills      = 0;
	int drops      = 0;

	`include "iq_ref_model.svh"

	issue_queue issue_queue_i (
		.i_clk    (clk),
		.i_arst_n (arst_n),
		.i_en     (en),
		.i_entry1 (entry[0]),
		.i_entry2 (entry[1]),
		.i_entry3 (entry[2]),
		.i_entry4 (entry[3]),
		.i_wb     (wb),
		.i_brkill (brkill),
		.o_full   (full),
		.o_issue1 (issue1),
		.o_issue2 (issue2),
		.o_valid1 (valid1),
		.o_valid2 (valid2)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic idle_inputs();
		en     = 1'b0;
		wb     = '0;
		brkill = '0;
		for (int k = 0; k < 4; k++) begin
			entry[k] = '0;
		end
	endtask

	task automatic random_writeback();
		for (int p = 0; p < IQ_WB_PORTS; p++) begin
			wb.port[p].valid = ($urandom % 2) == 1;
			wb.port[p].tag   = iq_reg_t'($urandom);
		end
	endtask

	task automatic drive_random();
		logic [63:0] bits;
		en = ($urandom % 4) != 0; // Mostly inserting, so the queue runs full.
		for (int k = 0; k < 4; k++) begin
			bits           = {$urandom, $urandom};
			entry[k]       = bits[$bits(iq_entry_t)-1:0];
			entry[k].valid = ($urandom % 8) != 0;
			entry[k].rdy1  = ($urandom % 8) < 5;
			entry[k].rdy2  = ($urandom % 8) < 5;
		end
		brkill = iq_brm_t'((($urandom % 16) == 0) ? (1 << ($urandom % BRM_W)) : 0);
		random_writeback();
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] want);
		mismatches++;
		$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	task automatic finish_run();
		$display("Errors: %0d mismatches, %0d other; %0d issued, %0d dual, %0d killed, %0d dropped",
			mismatches, failures, issued, dual, kills, drops);
		if (mismatches == 0 && failures == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	// Inputs are stable at the falling edge, so the model runs there.
	always @(negedge clk) begin
		logic    exp_full;
		logic    exp_v1;
		logic    exp_v2;
		iq_uop_t exp_u1;
		iq_uop_t exp_u2;
		int      k1;
		int      k2;
		if (arst_n !== 1'b1) begin
			for (int c = 0; c < 2; c++) begin
				for (int r = 0; r < IQ_LENGTH; r++) begin
					col_img[c][r] = '0;
				end
			end
		end else begin
			exp_full = held_count(1'b1) != 0;
			exp_v1 = step_column(0, entry[0], entry[2], en && !exp_full, wb, brkill, exp_u1, k1);
			exp_v2 = step_column(1, entry[1], entry[3], en && !exp_full, wb, brkill, exp_u2, k2);
			assert (full === exp_full) else report_mismatch("o_full", 32'(full), 32'(exp_full));
			assert (valid1 === exp_v1) else report_mismatch("o_valid1", 32'(valid1), 32'(exp_v1));
			assert (valid2 === exp_v2) else report_mismatch("o_valid2", 32'(valid2), 32'(exp_v2));
			assert (issue1 === exp_u1) else report_mismatch("o_issue1", 32'(issue1), 32'(exp_u1));
			assert (issue2 === exp_u2) else report_mismatch("o_issue2", 32'(issue2), 32'(exp_u2));
			drops  += int'(en && exp_full);
			kills  += k1 + k2;
			issued += int'(exp_v1) + int'(exp_v2);
			dual   += int'(exp_v1 && exp_v2);
		end
	end

	initial begin
		void'($urandom(32'h9509aeec));
		clk    = 1'b0;
		arst_n = 1'b0;
		idle_inputs();
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;
		repeat (4) @(posedge clk);
		for (int n = 0; n < STIM_CYCLES; n++) begin
			@(posedge clk);
			#1;
			drive_random();
		end
		// The last random cycle reaches the model before the drain looks at it.
		@(posedge clk);
		#1;
		idle_inputs();
		random_writeback();
		// Writebacks keep coming so that waiting entries can still wake up.
		for (int n = 0; n < DRAIN_CYCLES && held_count(1'b0) != 0; n++) begin
			@(posedge clk);
			#1;
			idle_inputs();
			random_writeback();
		end
		@(posedge clk);
		#1;
		idle_inputs();
		repeat (2) @(posedge clk);
		#1;
		assert (held_count(1'b0) == 0 && full === 1'b0) else begin
			failures++;
			$display("The queue still held entries after the drain period");
		end
		assert (drops > 0 && kills > 0 && dual > 0) else begin
			failures++;
			$display("The random stimulus never reached a full queue, a kill or a dual issue");
		end
		finish_run();
	end

	initial begin
		#(LIMIT_NS);
		failures++;
		$display("Timeout after %0d ns, the run hung before the final checks", LIMIT_NS);
		finish_run();
	end

endmodule

`default_nettype wire

/* issue_queue.f */
+incdir+dv
hdl/iq_cfg_pkg.sv
hdl/iq_types_pkg.sv
hdl/iq_slot.sv
hdl/iq_select.sv
hdl/issue_queue.sv
dv/tb_issue_queue.sv
